// ==== source/spi_flash_pkg.sv ====
package spi_flash_pkg;

   // flash side widths
   localparam int FLASH_ADDR_W = 24;
   localparam int FLASH_BYTE_W = 8;
   localparam int FLASH_WORD_W = 32;

   typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;   // byte address inside the flash
   typedef logic [FLASH_BYTE_W-1:0] flash_byte_t;   // one byte on the wire
   typedef logic [FLASH_WORD_W-1:0] flash_word_t;   // four bytes, first one in the MSBs

   // opcodes
   localparam flash_byte_t CMD_READ = 8'h03;
   localparam flash_byte_t CMD_WAKE = 8'hAB;   // release from deep power down
   localparam flash_byte_t CMD_WREN = 8'h06;   // write enable

   // each bit spans eight clk cycles, SCK falls at phase 0
   localparam logic [2:0] PHASE_SCK_RISE = 3'd4;
   localparam logic [2:0] PHASE_SAMPLE   = 3'd6;

   // idle clocks after the wake and write enable frames
   // real parts want tens of microseconds here
   localparam logic [15:0] WAKE_WAIT_CYCLES = 16'd200;

endpackage

// ==== source/wb_pkg.sv ====
package wb_pkg;

   localparam int WB_DATA_W = 32;
   localparam int WB_ADR_W  = 2;

   typedef logic [WB_DATA_W-1:0] wb_word_t;
   typedef logic [WB_ADR_W-1:0]  wb_reg_addr_t;   // word offset

   // register map
   localparam wb_reg_addr_t REG_ADDR   = 2'd0;   // write starts a read
   localparam wb_reg_addr_t REG_DATA   = 2'd1;   // read clears valid
   localparam wb_reg_addr_t REG_STATUS = 2'd2;

   // status word bits
   localparam int STAT_READY = 0;
   localparam int STAT_BUSY  = 1;
   localparam int STAT_VALID = 2;

endpackage

// ==== source/spi_byte_if.sv ====
`timescale 1ns/1ps

interface spi_byte_if import spi_flash_pkg::*; ();

   logic        start;     // one cycle, only while busy is low
   logic        last;      // release chip select after this byte
   flash_byte_t tx_byte;
   flash_byte_t rx_byte;   // valid while done is high
   logic        done;
   logic        busy;

   modport sequencer (
      output start, last, tx_byte,
      input  rx_byte, done, busy
   );

   modport engine (
      input  start, last, tx_byte,
      output rx_byte, done, busy
   );

endinterface

// ==== source/flash_req_if.sv ====
`timescale 1ns/1ps

interface flash_req_if import spi_flash_pkg::*; ();

   logic        req;           // one cycle pulse
   flash_addr_t addr;
   logic        ready;         // init sequence finished
   logic        busy;
   logic        valid_pulse;   // data is final in this cycle
   flash_word_t data;

   modport regs (
      output req, addr,
      input  ready, busy, valid_pulse, data
   );

   modport sequencer (
      input  req, addr,
      output ready, busy, valid_pulse, data
   );

endinterface

// ==== source/spi_shift_engine.sv ====
`timescale 1ns/1ps

module spi_shift_engine import spi_flash_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   spi_byte_if.engine bus,
   output logic       spi_sck,
   output logic       spi_cs_n,
   output logic       spi_mosi,
   input  logic       spi_miso
);

   logic [2:0]  phase;        // position inside the current bit
   logic [2:0]  bit_cnt;
   flash_byte_t shreg;        // tx bits leave at the top, rx bits enter at the bottom
   logic        miso_bit;
   logic        frame_last;   // chip select goes high after this byte
   logic        busy_q;
   logic        done_q;

   assign bus.busy    = busy_q;
   assign bus.done    = done_q;
   assign bus.rx_byte = shreg;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q     <= 1'b0;
         done_q     <= 1'b0;
         phase      <= 3'd0;
         bit_cnt    <= 3'd0;
         frame_last <= 1'b1;
         spi_sck    <= 1'b0;
         spi_cs_n   <= 1'b1;
         spi_mosi   <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (done_q && frame_last)
            spi_cs_n <= 1'b1;

         if (bus.start) begin
            // the start cycle already counts as phase 0 of the first bit
            busy_q     <= 1'b1;
            phase      <= 3'd1;
            bit_cnt    <= 3'd0;
            frame_last <= bus.last;
            spi_cs_n   <= 1'b0;
            spi_sck    <= 1'b0;
            spi_mosi   <= bus.tx_byte[7];
         end else if (busy_q) begin
            phase <= phase + 3'd1;
            if (phase == 3'd0) begin
               spi_sck  <= 1'b0;   // mode 0, data changes on the falling edge
               spi_mosi <= shreg[7];
            end
            if (phase == PHASE_SCK_RISE)
               spi_sck <= 1'b1;
            if (phase == 3'd7) begin
               bit_cnt <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  busy_q   <= 1'b0;
                  done_q   <= 1'b1;
                  spi_sck  <= 1'b0;   // back to idle level, also the flash shift edge
                  spi_mosi <= 1'b0;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (bus.start)
         shreg <= bus.tx_byte;
      else if (busy_q && phase == 3'd7)
         shreg <= {shreg[6:0], miso_bit};
      if (busy_q && phase == PHASE_SAMPLE)
         miso_bit <= spi_miso;   // mid high period of SCK
   end

   // once a closing frame is over the flash must be deselected until the next start
   a_cs_idle: assert property (@(posedge clk) disable iff (reset)
      (!busy_q && !done_q && frame_last) |-> spi_cs_n);

   a_sck_low_when_idle: assert property (@(posedge clk) disable iff (reset)
      spi_cs_n |-> !spi_sck);

endmodule

// ==== source/flash_read_sequencer.sv ====
`timescale 1ns/1ps

module flash_read_sequencer import spi_flash_pkg::*; (
   input  logic            clk,
   input  logic            reset,
   spi_byte_if.sequencer   spi,
   flash_req_if.sequencer  req
);

   typedef enum logic [3:0] {
      WAKE, WAKE_WAIT, WREN, WREN_WAIT, IDLE, CMD, ADDR, DATA, FINISH
   } state_t;

   state_t      state;
   logic        wake_sent;
   logic [15:0] wait_cnt;
   logic [1:0]  byte_idx;    // address byte, then data byte
   flash_addr_t addr_q;
   flash_word_t word_q;
   logic        accept;      // new read taken this cycle

   function automatic flash_byte_t addr_byte(flash_addr_t a, logic [1:0] idx);
      case (idx)
         2'd0:    return a[23:16];
         2'd1:    return a[15:8];
         default: return a[7:0];
      endcase
   endfunction

   // FINISH takes a request too, ready and not busy are both shown there
   assign accept          = req.req && (state == IDLE || state == FINISH);
   assign req.ready       = state inside {IDLE, CMD, ADDR, DATA, FINISH};
   assign req.busy        = state inside {CMD, ADDR, DATA};
   assign req.valid_pulse = (state == FINISH);
   assign req.data        = word_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= WAKE;
         wake_sent   <= 1'b0;
         wait_cnt    <= '0;
         byte_idx    <= 2'd0;
         spi.start   <= 1'b0;
         spi.last    <= 1'b0;
         spi.tx_byte <= '0;
      end else begin
         spi.start <= 1'b0;
         case (state)
            WAKE: begin
               if (!wake_sent) begin
                  wake_sent   <= 1'b1;
                  spi.start   <= 1'b1;
                  spi.tx_byte <= CMD_WAKE;
                  spi.last    <= 1'b1;   // single byte frame
               end else if (spi.done) begin
                  wait_cnt <= '0;
                  state    <= WAKE_WAIT;
               end
            end
            WAKE_WAIT: begin
               wait_cnt <= wait_cnt + 16'd1;
               if (wait_cnt == WAKE_WAIT_CYCLES - 16'd1) begin
                  spi.start   <= 1'b1;
                  spi.tx_byte <= CMD_WREN;
                  spi.last    <= 1'b1;
                  state       <= WREN;
               end
            end
            WREN: if (spi.done) begin
               wait_cnt <= '0;
               state    <= WREN_WAIT;
            end
            WREN_WAIT: begin
               wait_cnt <= wait_cnt + 16'd1;
               if (wait_cnt == WAKE_WAIT_CYCLES - 16'd1)
                  state <= IDLE;
            end
            IDLE, FINISH: begin
               if (accept) begin
                  spi.start   <= 1'b1;
                  spi.tx_byte <= CMD_READ;
                  spi.last    <= 1'b0;
                  state       <= CMD;
               end else begin
                  state <= IDLE;
               end
            end
            CMD: if (spi.done) begin
               byte_idx    <= 2'd0;
               spi.start   <= 1'b1;
               spi.tx_byte <= addr_byte(addr_q, 2'd0);
               state       <= ADDR;
            end
            ADDR: if (spi.done) begin
               spi.start <= 1'b1;
               if (byte_idx == 2'd2) begin
                  byte_idx    <= 2'd0;
                  spi.tx_byte <= '0;   // dummy byte while data comes in
                  state       <= DATA;
               end else begin
                  byte_idx    <= byte_idx + 2'd1;
                  spi.tx_byte <= addr_byte(addr_q, byte_idx + 2'd1);
               end
            end
            DATA: if (spi.done) begin
               if (byte_idx == 2'd3) begin
                  state <= FINISH;
               end else begin
                  byte_idx  <= byte_idx + 2'd1;
                  spi.start <= 1'b1;
                  spi.last  <= (byte_idx == 2'd2);   // fourth data byte closes the frame
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         addr_q <= req.addr;
      if (state == DATA && spi.done)
         word_q <= {word_q[23:0], spi.rx_byte};   // msb first
   end

   a_start_when_free: assert property (@(posedge clk) disable iff (reset)
      spi.start |-> !spi.busy);

endmodule

// ==== source/wb_flash_regs.sv ====
`timescale 1ns/1ps

module wb_flash_regs import wb_pkg::*; import spi_flash_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         wb_we,
   input  wb_reg_addr_t wb_adr,
   input  wb_word_t     wb_wdata,
   output wb_word_t     wb_rdata,
   output logic         wb_ack,
   flash_req_if.regs    req
);

   logic     access;   // first cycle of a bus access
   logic     issue;
   logic     valid_q;
   wb_word_t data_q;
   wb_word_t status;

   assign access = wb_cyc && wb_stb && !wb_ack;

   // writes while a read runs or before init are acked and dropped
   assign issue = access && wb_we && (wb_adr == REG_ADDR)
                  && req.ready && !req.busy && !req.req;

   always_comb begin
      status             = '0;
      status[STAT_READY] = req.ready;
      status[STAT_BUSY]  = req.busy;
      status[STAT_VALID] = valid_q;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack  <= 1'b0;
         req.req <= 1'b0;
         valid_q <= 1'b0;
      end else begin
         wb_ack  <= access;
         req.req <= issue;
         if (req.valid_pulse)
            valid_q <= 1'b1;   // a fresh word wins over a clearing read
         else if (access && !wb_we && wb_adr == REG_DATA)
            valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (issue)
         req.addr <= flash_addr_t'(wb_wdata);
      if (req.valid_pulse)
         data_q <= req.data;
      if (access && !wb_we) begin
         case (wb_adr)
            REG_ADDR:   wb_rdata <= wb_word_t'(req.addr);
            REG_DATA:   wb_rdata <= data_q;
            REG_STATUS: wb_rdata <= status;
            default:    wb_rdata <= '0;
         endcase
      end
   end

   // the sequencer still shows ready and idle when the request pulse arrives
   a_req_when_free: assert property (@(posedge clk) disable iff (reset)
      req.req |-> (req.ready && !req.busy));

endmodule

// ==== source/spi_flash_reader.sv ====
`timescale 1ns/1ps

module spi_flash_reader import wb_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  logic         wb_cyc,
   input  logic         wb_stb,
   input  logic         wb_we,
   input  wb_reg_addr_t wb_adr,
   input  wb_word_t     wb_wdata,
   output wb_word_t     wb_rdata,
   output logic         wb_ack,
   output logic         spi_sck,
   output logic         spi_cs_n,
   output logic         spi_mosi,
   input  logic         spi_miso
);

   flash_req_if req_bus ();    // registers to sequencer
   spi_byte_if  byte_bus ();   // sequencer to shifter

   wb_flash_regs u_regs (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack),
      .req      (req_bus.regs)
   );

   flash_read_sequencer u_seq (
      .clk   (clk),
      .reset (reset),
      .spi   (byte_bus.sequencer),
      .req   (req_bus.sequencer)
   );

   spi_shift_engine u_engine (
      .clk      (clk),
      .reset    (reset),
      .bus      (byte_bus.engine),
      .spi_sck  (spi_sck),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

endmodule

// ==== test/flash_model.sv ====
`timescale 1ns/1ps

module flash_model import spi_flash_pkg::*; (
   input  logic sck,
   input  logic cs_n,
   input  logic mosi,
   output logic miso
);

   logic [31:0] shreg;      // opcode and address bits as they arrive
   int          bit_cnt;    // bits clocked in since chip select fell
   flash_byte_t opcode;
   flash_addr_t rd_addr;
   flash_addr_t byte_addr;
   flash_byte_t out_byte;
   logic [2:0]  out_pos;
   int          data_bit;
   logic        prev_sck;
   logic        prev_cs_n;

   // frame counters, read by the testbench
   int          wake_frames;
   int          wren_frames;
   int          read_frames;
   int          bad_frames;
   flash_byte_t last_op;

   // one process follows both pins and keeps the edge order
   initial begin
      miso        = 1'b0;
      shreg       = '0;
      bit_cnt     = 0;
      opcode      = '0;
      rd_addr     = '0;
      wake_frames = 0;
      wren_frames = 0;
      read_frames = 0;
      bad_frames  = 0;
      last_op     = '0;
      prev_sck    = 1'b0;
      prev_cs_n   = 1'b1;
      forever begin
         @(sck or cs_n);
         if (prev_cs_n && !cs_n) begin
            bit_cnt = 0;   // new opcode follows
            opcode  = '0;
         end
         if (!cs_n && !prev_sck && sck) begin
            shreg   = {shreg[30:0], mosi};   // sample on the rising edge
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin
               opcode  = shreg[7:0];
               last_op = opcode;
               case (opcode)
                  CMD_WAKE: wake_frames = wake_frames + 1;
                  CMD_WREN: wren_frames = wren_frames + 1;
                  CMD_READ: read_frames = read_frames + 1;
                  default: begin
                     bad_frames = bad_frames + 1;
                     $display("flash model saw unknown opcode %h", opcode);
                  end
               endcase
            end
            if (bit_cnt == 32 && opcode == CMD_READ)
               rd_addr = shreg[23:0];
         end
         if (!cs_n && prev_sck && !sck && opcode == CMD_READ && bit_cnt >= 32) begin
            // next data bit goes out on the falling edge
            data_bit  = bit_cnt - 32;
            byte_addr = rd_addr + flash_addr_t'(data_bit / 8);   // wraps at the top
            out_byte  = byte_addr[7:0] ^ 8'h5A;
            out_pos   = 3'(7 - (data_bit % 8));
            miso      = out_byte[out_pos];
         end
         prev_sck  = sck;
         prev_cs_n = cs_n;
      end
   end

endmodule

// ==== test/tb_spi_flash_reader.sv ====
`timescale 1ns/1ps

module tb_spi_flash_reader import wb_pkg::*, spi_flash_pkg::*; ();

   localparam int NUM_READS   = 10;    // real flash reads over all tests
   localparam int INIT_CYCLES = 2 * 64 + 2 * int'(WAKE_WAIT_CYCLES);
   localparam int WATCHDOG    = NUM_READS * 600 + INIT_CYCLES + 2000;
   localparam int ACK_LIMIT   = 20;
   localparam int POLL_LIMIT  = 400;

   localparam wb_word_t READY_MASK = 32'h1 << STAT_READY;
   localparam wb_word_t BUSY_MASK  = 32'h1 << STAT_BUSY;
   localparam wb_word_t VALID_MASK = 32'h1 << STAT_VALID;

   logic         clk;
   logic         reset;
   logic         wb_cyc;
   logic         wb_stb;
   logic         wb_we;
   wb_reg_addr_t wb_adr;
   wb_word_t     wb_wdata;
   wb_word_t     wb_rdata;
   logic         wb_ack;
   logic         spi_sck;
   logic         spi_cs_n;
   logic         spi_mosi;
   logic         spi_miso;

   int          errors = 0;
   int          checks = 0;
   logic [31:0] lfsr   = 32'h9ad5f929;

   spi_flash_reader u_dut (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_wdata (wb_wdata),
      .wb_rdata (wb_rdata),
      .wb_ack   (wb_ack),
      .spi_sck  (spi_sck),
      .spi_cs_n (spi_cs_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

   flash_model u_flash (
      .sck  (spi_sck),
      .cs_n (spi_cs_n),
      .mosi (spi_mosi),
      .miso (spi_miso)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG);
      $display("Regression failed");
      $finish;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Fail %s: got %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic random_addr(output flash_addr_t a);
      for (int i = 0; i < 24; i++) begin
         lfsr = lfsr_next(lfsr);
         a    = {a[22:0], lfsr[0]};   // one step per bit
      end
   endtask

   function automatic flash_byte_t flash_byte_at(input flash_addr_t a);
      return a[7:0] ^ 8'h5A;
   endfunction

   // first byte lands in the top bits
   function automatic wb_word_t expected_word(input flash_addr_t a);
      flash_addr_t a1;
      flash_addr_t a2;
      flash_addr_t a3;
      a1 = a + 24'd1;
      a2 = a + 24'd2;
      a3 = a + 24'd3;
      return {flash_byte_at(a), flash_byte_at(a1), flash_byte_at(a2), flash_byte_at(a3)};
   endfunction

   task automatic bus_access(input logic we, input wb_reg_addr_t adr, input wb_word_t wdata,
                             output wb_word_t rdata);
      int waited;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_wdata = wdata;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      if (!wb_ack) begin
         $display("No ack within %0d cycles for offset %0d", ACK_LIMIT, adr);
         errors++;
      end else begin
         check("wb_ack latency", waited, 1);
      end
      rdata  = wb_rdata;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      @(negedge clk);
      check("wb_ack width", 32'(wb_ack), 32'd0);   // one cycle only
   endtask

   task automatic wb_write(input wb_reg_addr_t adr, input wb_word_t data);
      wb_word_t unused;
      bus_access(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input wb_reg_addr_t adr, output wb_word_t data);
      bus_access(1'b0, adr, '0, data);
   endtask

   task automatic poll_status(input wb_word_t mask);
      wb_word_t st;
      int       n;
      st = '0;
      n  = 0;
      while ((st & mask) == '0 && n < POLL_LIMIT) begin
         wb_read(REG_STATUS, st);
         n++;
      end
      if ((st & mask) == '0) begin
         $display("Status bits %h never came up in %0d reads", mask, POLL_LIMIT);
         errors++;
      end
   endtask

   task automatic read_word(input flash_addr_t a, output wb_word_t data);
      wb_write(REG_ADDR, wb_word_t'(a));
      poll_status(VALID_MASK);
      wb_read(REG_DATA, data);
   endtask

   task automatic test_reset_state();
      wb_word_t st;
      wb_read(REG_STATUS, st);
      check("status after reset", st, '0);
      poll_status(READY_MASK);
      check("wake frames", u_flash.wake_frames, 1);
      check("wren frames", u_flash.wren_frames, 1);
      check("read frames after init", u_flash.read_frames, 0);
      check("last init opcode", 32'(u_flash.last_op), 32'(CMD_WREN));
   endtask

   task automatic test_single_read();
      wb_word_t st;
      wb_word_t data;
      wb_write(REG_ADDR, 32'h0000_0100);
      wb_read(REG_STATUS, st);
      check("status busy during read", st & BUSY_MASK, BUSY_MASK);
      poll_status(VALID_MASK);
      wb_read(REG_STATUS, st);
      check("status busy after read", st & BUSY_MASK, '0);
      wb_read(REG_DATA, data);
      check("data at 000100", data, expected_word(24'h000100));
   endtask

   task automatic test_valid_clear();
      wb_word_t st;
      wb_read(REG_STATUS, st);
      check("status valid after data read", st & VALID_MASK, '0);
   endtask

   task automatic test_busy_write();
      wb_word_t data;
      int       frames0;
      frames0 = u_flash.read_frames;
      wb_write(REG_ADDR, 32'h0000_ABCD);
      wb_write(REG_ADDR, 32'h0012_3456);   // lands while busy, dropped
      poll_status(VALID_MASK);
      wb_read(REG_DATA, data);
      check("data after dropped write", data, expected_word(24'h00ABCD));
      wb_read(REG_ADDR, data);
      check("address register", data, 32'h0000_ABCD);
      check("read frames for one request", u_flash.read_frames - frames0, 1);
   endtask

   task automatic test_random_reads();
      flash_addr_t a;
      wb_word_t    data;
      for (int i = 0; i < 8; i++) begin
         random_addr(a);
         if (i == 5)
            a = 24'hFFFFFE;   // crosses the top of the address space
         read_word(a, data);
         check($sformatf("data at %h", a), data, expected_word(a));
      end
   endtask

   task automatic test_unused_offset();
      wb_word_t data;
      wb_read(2'd3, data);
      check("offset 3", data, '0);
   endtask

   initial begin
      reset    = 1'b1;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_wdata = '0;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      test_reset_state();
      test_single_read();
      test_valid_clear();
      test_busy_write();
      test_random_reads();
      test_unused_offset();
      check("unknown opcode frames", u_flash.bad_frames, 0);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

// ==== spi_flash_reader.f ====
source/spi_flash_pkg.sv
source/wb_pkg.sv
source/spi_byte_if.sv
source/flash_req_if.sv
source/spi_shift_engine.sv
source/flash_read_sequencer.sv
source/wb_flash_regs.sv
source/spi_flash_reader.sv
test/flash_model.sv
test/tb_spi_flash_reader.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide on the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_spi_flash_reader \
   -f spi_flash_reader.f -o tb_sim > build.log 2>&1 ||
   { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Regression passed" sim.log && echo "simulation ok" ||
   { echo "simulation failed, see sim.log"; exit 1; }
